// ==== verilog/ps2_kbd_pkg.sv ====
package ps2_kbd_pkg;

	// PS/2 frame: start, 8 data bits LSB first, odd parity, stop
	localparam int FRAME_BITS = 11;
	localparam int BIT_CNT_W = $clog2(FRAME_BITS);
	localparam int FILTER_LEN = 4;        // Samples the clock line must hold
	localparam int IDLE_TIMEOUT = 2000;   // System clocks before a partial frame is dropped
	localparam int IDLE_CNT_W = $clog2(IDLE_TIMEOUT);

	localparam logic [7:0] CODE_EXT = 8'hE0;    // Extended prefix
	localparam logic [7:0] CODE_BREAK = 8'hF0;  // Break prefix

	// Set 2 scan codes
	localparam logic [7:0] KEY_1 = 8'h16;
	localparam logic [7:0] KEY_2 = 8'h1E;
	localparam logic [7:0] KEY_3 = 8'h26;
	localparam logic [7:0] KEY_4 = 8'h25;
	localparam logic [7:0] KEY_W = 8'h1D;
	localparam logic [7:0] KEY_A = 8'h1C;
	localparam logic [7:0] KEY_S = 8'h1B;
	localparam logic [7:0] KEY_D = 8'h23;
	localparam logic [7:0] KEY_NUM = 8'h77;
	localparam logic [7:0] KEY_SLASH = 8'h4A;   // Keypad /, needs E0
	localparam logic [7:0] KEY_STAR = 8'h7C;
	localparam logic [7:0] KEY_MINUS = 8'h7B;
	localparam logic [7:0] KEY_UP = 8'h75;      // Arrows need E0
	localparam logic [7:0] KEY_DOWN = 8'h72;
	localparam logic [7:0] KEY_LEFT = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;

	// Bit positions in the joystick word
	localparam logic [3:0] JOY_RIGHT = 4'd0;
	localparam logic [3:0] JOY_LEFT = 4'd1;
	localparam logic [3:0] JOY_DOWN = 4'd2;
	localparam logic [3:0] JOY_UP = 4'd3;
	localparam logic [3:0] JOY_B1 = 4'd4;
	localparam logic [3:0] JOY_B2 = 4'd5;
	localparam logic [3:0] JOY_B3 = 4'd6;
	localparam logic [3:0] JOY_B4 = 4'd7;
	localparam logic [3:0] JOY_D = 4'd8;
	localparam logic [3:0] JOY_A = 4'd9;
	localparam logic [3:0] JOY_S = 4'd10;
	localparam logic [3:0] JOY_W = 4'd11;
	localparam logic [3:0] JOY_NUM = 4'd12;
	localparam logic [3:0] JOY_SLASH = 4'd13;
	localparam logic [3:0] JOY_STAR = 4'd14;
	localparam logic [3:0] JOY_MINUS = 4'd15;

	typedef struct packed {
		logic [7:0] code;
		logic       released;   // Break event when set
		logic       extended;   // Preceded by E0
	} key_event_t;

	typedef struct packed {
		logic [7:0] code;
		logic       extended;
		logic [3:0] joy_bit;
	} key_map_t;

	localparam int KEY_COUNT = 16;

	localparam key_map_t KEY_MAP [KEY_COUNT] = '{
		'{KEY_1,     1'b0, JOY_B1},
		'{KEY_2,     1'b0, JOY_B2},
		'{KEY_3,     1'b0, JOY_B3},
		'{KEY_4,     1'b0, JOY_B4},
		'{KEY_W,     1'b0, JOY_W},
		'{KEY_A,     1'b0, JOY_A},
		'{KEY_S,     1'b0, JOY_S},
		'{KEY_D,     1'b0, JOY_D},
		'{KEY_NUM,   1'b0, JOY_NUM},
		'{KEY_SLASH, 1'b1, JOY_SLASH},
		'{KEY_STAR,  1'b0, JOY_STAR},
		'{KEY_MINUS, 1'b0, JOY_MINUS},
		'{KEY_UP,    1'b1, JOY_UP},
		'{KEY_DOWN,  1'b1, JOY_DOWN},
		'{KEY_LEFT,  1'b1, JOY_LEFT},
		'{KEY_RIGHT, 1'b1, JOY_RIGHT}
	};

endpackage

// ==== verilog/key_event_if.sv ====
interface key_event_if;

	logic                    valid;  // One-cycle strobe
	ps2_kbd_pkg::key_event_t ev;     // Only meaningful while valid is high

	// Parser side
	modport source (
		output valid,
		output ev
	);

	// Mapper side
	modport sink (
		input valid,
		input ev
	);

endinterface

// ==== verilog/ps2_frame_rx.sv ====
module ps2_frame_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic       byte_valid,
	output logic [7:0] byte_data,
	output logic       frame_error
);

	localparam int FB = ps2_kbd_pkg::FRAME_BITS;
	localparam int FL = ps2_kbd_pkg::FILTER_LEN;
	localparam int BCW = ps2_kbd_pkg::BIT_CNT_W;
	localparam int ICW = ps2_kbd_pkg::IDLE_CNT_W;

	logic [1:0]     ps2_clk_sync;
	logic [1:0]     ps2_data_sync;
	logic [FL-1:0]  clk_hist;
	logic           clk_filt;
	logic           clk_low;
	logic           clk_high;
	logic           fall_edge;
	logic           data_bit;

	logic [FB-1:0]  shift_reg;
	logic [FB-1:0]  frame;
	logic [BCW-1:0] bit_cnt;
	logic           last_bit;
	logic           frame_ok;
	logic [ICW-1:0] idle_cnt;
	logic           idle_expired;

	// Two-flop synchronizers, idle level is high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ps2_clk_sync <= 2'b11;
			ps2_data_sync <= 2'b11;
		end else begin
			ps2_clk_sync <= {ps2_clk_sync[0], ps2_clk};
			ps2_data_sync <= {ps2_data_sync[0], ps2_data};
		end
	end

	// Glitch filter on the clock line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_hist <= '1;
			clk_filt <= 1'b1;
		end else begin
			clk_hist <= {clk_hist[FL-2:0], ps2_clk_sync[1]};
			if (clk_low)
				clk_filt <= 1'b0;
			else if (clk_high)
				clk_filt <= 1'b1;
		end
	end

	assign clk_low = (clk_hist == '0);     // Stable low for FL samples
	assign clk_high = (clk_hist == '1);
	assign fall_edge = clk_filt & clk_low;
	assign data_bit = ps2_data_sync[1];

	// Bits arrive LSB first, so new bits enter at the top
	assign frame = {data_bit, shift_reg[FB-1:1]};
	assign last_bit = (bit_cnt == BCW'(FB - 1));

	// Start 0, stop 1, odd parity over data plus parity
	assign frame_ok = ~frame[0] & frame[FB-1] & (^frame[FB-2:1]);

	assign idle_expired = (idle_cnt == ICW'(ps2_kbd_pkg::IDLE_TIMEOUT - 1));

	always_ff @(posedge clk) begin
		if (fall_edge)
			shift_reg <= frame;
		if (fall_edge && last_bit)
			byte_data <= frame[8:1];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			byte_valid <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			frame_error <= 1'b0;
			if (fall_edge) begin
				if (last_bit) begin
					bit_cnt <= '0;
					byte_valid <= frame_ok;
					frame_error <= ~frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (idle_expired) begin
				bit_cnt <= '0;             // Drop partial frame
			end
		end
	end

	// Idle counter only runs while a frame is partly received
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idle_cnt <= '0;
		end else begin
			if (fall_edge || bit_cnt == '0 || idle_expired)
				idle_cnt <= '0;
			else
				idle_cnt <= idle_cnt + 1'b1;
		end
	end

endmodule

// ==== verilog/scancode_parser.sv ====
module scancode_parser (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        byte_valid,
	input  logic [7:0]  byte_data,
	key_event_if.source evt
);

	logic ext_pend;   // E0 seen
	logic rel_pend;   // F0 seen
	logic is_ext;
	logic is_break;
	logic is_code;

	assign is_ext = (byte_data == ps2_kbd_pkg::CODE_EXT);
	assign is_break = (byte_data == ps2_kbd_pkg::CODE_BREAK);
	assign is_code = byte_valid & ~is_ext & ~is_break;

	// Prefix flags and event strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ext_pend <= 1'b0;
			rel_pend <= 1'b0;
			evt.valid <= 1'b0;
		end else begin
			evt.valid <= is_code;
			if (byte_valid) begin
				if (is_ext) begin
					ext_pend <= 1'b1;
				end else if (is_break) begin
					rel_pend <= 1'b1;
				end else begin
					ext_pend <= 1'b0;   // Flags apply to one code only
					rel_pend <= 1'b0;
				end
			end
		end
	end

	// Event payload, captured together with the strobe
	always_ff @(posedge clk) begin
		if (is_code) begin
			evt.ev.code <= byte_data;
			evt.ev.released <= rel_pend;
			evt.ev.extended <= ext_pend;
		end
	end

endmodule

// ==== verilog/joystick_mapper.sv ====
module joystick_mapper (
	input  logic        clk,
	input  logic        rst_n,
	key_event_if.sink   evt,
	output logic [15:0] joystick
);

	logic       hit;
	logic [3:0] hit_bit;

	// Table lookup; code and extended flag must both match
	always_comb begin
		hit = 1'b0;
		hit_bit = '0;
		for (int i = 0; i < ps2_kbd_pkg::KEY_COUNT; i++) begin
			if (evt.ev.code == ps2_kbd_pkg::KEY_MAP[i].code &&
				evt.ev.extended == ps2_kbd_pkg::KEY_MAP[i].extended) begin
				hit = 1'b1;
				hit_bit = ps2_kbd_pkg::KEY_MAP[i].joy_bit;
			end
		end
	end

	// Pressed keys read as 1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			joystick <= '0;
		end else if (evt.valid && hit) begin
			joystick[hit_bit] <= ~evt.ev.released;
		end
	end

endmodule

// ==== verilog/ps2_joystick_top.sv ====
module ps2_joystick_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	output logic [15:0] joystick,
	output logic        frame_error
);

	logic       byte_valid;
	logic [7:0] byte_data;

	key_event_if kev ();

	// Frame receiver
	ps2_frame_rx i_ps2_frame_rx (
		.clk         (clk),
		.rst_n       (rst_n),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.frame_error (frame_error)
	);

	// E0/F0 prefix handling
	scancode_parser i_scancode_parser (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.evt        (kev.source)
	);

	joystick_mapper i_joystick_mapper (
		.clk      (clk),
		.rst_n    (rst_n),
		.evt      (kev.sink),
		.joystick (joystick)
	);

endmodule

// ==== verification/ps2_device_model.sv ====
module ps2_device_model (
	input  logic clk,
	output logic ps2_clk,
	output logic ps2_data,
	output logic busy
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_CYCLES = 10;   // 40 ns at the 4 ns system clock
	localparam int GAP_CYCLES = ps2_kbd_pkg::IDLE_TIMEOUT + 100;

	// Lines idle high, as with the pull-ups on a real bus
	initial begin
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		busy = 1'b0;
	end

	// Every line change lands 1 ns after a rising system clock edge
	task automatic wait_half_period();
		repeat (HALF_CYCLES) @(posedge clk);
		#1;
	endtask

	// One 11-bit frame, LSB first after the start bit
	task automatic send_byte(input logic [7:0] value, input logic bad_parity);
		logic [10:0] frame;
		logic        parity;
		parity = ~^value;                  // Odd parity over data plus parity
		if (bad_parity)
			parity = ~parity;
		frame = {1'b1, parity, value, 1'b0};
		busy = 1'b1;
		@(posedge clk);
		#1;
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			wait_half_period();
			ps2_clk = 1'b0;                // Receiver samples on this edge
			wait_half_period();
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		wait_half_period();                // Short gap between bytes
		busy = 1'b0;
	endtask

	// Quiet bus for longer than the receiver's idle timeout
	task automatic idle_gap();
		busy = 1'b1;
		repeat (GAP_CYCLES) @(posedge clk);
		#1;
		busy = 1'b0;
	endtask

endmodule

// ==== verification/tb_ps2_joystick.sv ====
module tb_ps2_joystick;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int IDLE_WAIT_MAX = 5000;
	localparam int IDLE_SETTLE = 20;     // Sync, filter and two register stages fit inside
	localparam int RANDOM_EVENTS = 30;

	localparam logic [7:0] SC_EXT = 8'hE0;
	localparam logic [7:0] SC_BRK = 8'hF0;

	// Set 2 scan codes, indexed by joystick bit
	localparam logic [7:0] KEY_CODE [16] = '{
		8'h74, 8'h6B, 8'h72, 8'h75,        // Right, left, down, up
		8'h16, 8'h1E, 8'h26, 8'h25,        // Digits 1 to 4
		8'h23, 8'h1C, 8'h1B, 8'h1D,        // D, A, S, W
		8'h77, 8'h4A, 8'h7C, 8'h7B         // Num Lock, /, *, -
	};
	localparam logic [15:0] EXT_MASK = 16'b0010_0000_0000_1111;  // Keys that need E0

	typedef struct packed {
		int          n_bytes;
		logic [23:0] bytes;      // First byte in bits 7:0
		logic [2:0]  bad;        // Bad parity per byte
		logic        gap;        // Idle gap after the bytes
		logic [15:0] exp_joy;
		int          exp_err;
	} row_t;

	logic        clk;
	logic        rst_n;
	logic        ps2_clk;
	logic        ps2_data;
	logic        dev_busy;
	logic [15:0] joystick;
	logic        frame_error;

	row_t        rows[$];
	string       row_names[$];
	logic [15:0] last_exp;       // Running expected word
	int          err_pulses;
	int          fail_count;
	int          check_count;
	int          test_count;
	bit          timed_out;

	ps2_device_model i_dev (
		.clk      (clk),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.busy     (dev_busy)
	);

	ps2_joystick_top i_ps2_joystick_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.joystick    (joystick),
		.frame_error (frame_error)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Frame error pulse counter
	always @(negedge clk) begin
		if (rst_n && frame_error)
			err_pulses = err_pulses + 1;
	end

	function automatic logic [15:0] bitv(input int pos);
		return 16'(1) << pos;
	endfunction

	task automatic compare_value(input string sig, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			fail_count++;
			$display("FAILED t=%0t %s actual=%0h expected=%0h", $time, sig, actual, expected);
		end
	endtask

	task automatic add_row(input string name, input int n, input logic [7:0] b0,
		input logic [7:0] b1, input logic [7:0] b2, input logic [2:0] bad, input logic gap,
		input logic [15:0] set_bits, input logic [15:0] clr_bits, input int exp_err);
		row_t r;
		last_exp = (last_exp | set_bits) & ~clr_bits;
		r.n_bytes = n;
		r.bytes = {b2, b1, b0};
		r.bad = bad;
		r.gap = gap;
		r.exp_joy = last_exp;
		r.exp_err = exp_err;
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	// Expected word accumulates row by row
	task automatic build_table();
		last_exp = '0;
		add_row("make W", 1, 8'h1D, 8'h00, 8'h00, 3'b000, 1'b0, bitv(11), '0, 0);
		add_row("make A", 1, 8'h1C, 8'h00, 8'h00, 3'b000, 1'b0, bitv(9), '0, 0);
		add_row("make S", 1, 8'h1B, 8'h00, 8'h00, 3'b000, 1'b0, bitv(10), '0, 0);
		add_row("make D", 1, 8'h23, 8'h00, 8'h00, 3'b000, 1'b0, bitv(8), '0, 0);
		add_row("make 1", 1, 8'h16, 8'h00, 8'h00, 3'b000, 1'b0, bitv(4), '0, 0);
		add_row("make 2", 1, 8'h1E, 8'h00, 8'h00, 3'b000, 1'b0, bitv(5), '0, 0);
		add_row("make 3", 1, 8'h26, 8'h00, 8'h00, 3'b000, 1'b0, bitv(6), '0, 0);
		add_row("make 4", 1, 8'h25, 8'h00, 8'h00, 3'b000, 1'b0, bitv(7), '0, 0);
		add_row("make Num", 1, 8'h77, 8'h00, 8'h00, 3'b000, 1'b0, bitv(12), '0, 0);
		add_row("make *", 1, 8'h7C, 8'h00, 8'h00, 3'b000, 1'b0, bitv(14), '0, 0);
		add_row("make -", 1, 8'h7B, 8'h00, 8'h00, 3'b000, 1'b0, bitv(15), '0, 0);
		add_row("break A", 2, SC_BRK, 8'h1C, 8'h00, 3'b000, 1'b0, '0, bitv(9), 0);
		add_row("break Num", 2, SC_BRK, 8'h77, 8'h00, 3'b000, 1'b0, '0, bitv(12), 0);
		add_row("make up", 2, SC_EXT, 8'h75, 8'h00, 3'b000, 1'b0, bitv(3), '0, 0);
		add_row("make down", 2, SC_EXT, 8'h72, 8'h00, 3'b000, 1'b0, bitv(2), '0, 0);
		add_row("make left", 2, SC_EXT, 8'h6B, 8'h00, 3'b000, 1'b0, bitv(1), '0, 0);
		add_row("make right", 2, SC_EXT, 8'h74, 8'h00, 3'b000, 1'b0, bitv(0), '0, 0);
		add_row("make kp /", 2, SC_EXT, 8'h4A, 8'h00, 3'b000, 1'b0, bitv(13), '0, 0);
		add_row("break up", 3, SC_EXT, SC_BRK, 8'h75, 3'b000, 1'b0, '0, bitv(3), 0);
		// Keypad codes without E0 must not alias the arrows
		add_row("keypad 8", 1, 8'h75, 8'h00, 8'h00, 3'b000, 1'b0, '0, '0, 0);
		add_row("break keypad 4", 2, SC_BRK, 8'h6B, 8'h00, 3'b000, 1'b0, '0, '0, 0);
		add_row("break keypad 6", 2, SC_BRK, 8'h74, 8'h00, 3'b000, 1'b0, '0, '0, 0);
		add_row("E0 break W", 3, SC_EXT, SC_BRK, 8'h1D, 3'b000, 1'b0, '0, '0, 0);
		// Parity errors
		add_row("bad parity A", 1, 8'h1C, 8'h00, 8'h00, 3'b001, 1'b1, '0, '0, 1);
		add_row("make A after gap", 1, 8'h1C, 8'h00, 8'h00, 3'b000, 1'b0, bitv(9), '0, 0);
		add_row("bad E0 then 72", 2, SC_EXT, 8'h72, 8'h00, 3'b001, 1'b1, '0, '0, 1);
		add_row("unmapped 29", 1, 8'h29, 8'h00, 8'h00, 3'b000, 1'b0, '0, '0, 0);
		add_row("break unmapped 29", 2, SC_BRK, 8'h29, 8'h00, 3'b000, 1'b0, '0, '0, 0);
	endtask

	// Lines high and device quiet for IDLE_SETTLE cycles in a row
	task automatic wait_lines_idle();
		int cycles;
		int stable;
		cycles = 0;
		stable = 0;
		while (stable < IDLE_SETTLE && cycles < IDLE_WAIT_MAX) begin
			@(posedge clk);
			cycles++;
			if (ps2_clk && ps2_data && !dev_busy)
				stable++;
			else
				stable = 0;
		end
		if (stable < IDLE_SETTLE) begin
			timed_out = 1'b1;
			$display("ERROR: wait for idle PS/2 lines timed out after %0d cycles", IDLE_WAIT_MAX);
		end
		@(negedge clk);                    // Sample away from the rising edge
	endtask

	task automatic run_row(input int idx);
		row_t r;
		int   err_before;
		int   fails_before;
		r = rows[idx];
		err_before = err_pulses;
		fails_before = fail_count;
		for (int j = 0; j < r.n_bytes; j++)
			i_dev.send_byte(r.bytes[j*8 +: 8], r.bad[j]);
		if (r.gap)
			i_dev.idle_gap();
		wait_lines_idle();
		test_count++;
		if (!timed_out) begin
			compare_value("joystick", 32'(joystick), 32'(r.exp_joy));
			compare_value("frame_error count", 32'(err_pulses - err_before), 32'(r.exp_err));
			$display("test %0d %s: %s", idx, row_names[idx],
				(fail_count == fails_before) ? "ok" : "mismatch");
		end
	endtask

	// Random presses and releases against a bit-per-key model
	task automatic run_random_events();
		logic [15:0] model_joy;
		int          k;
		logic        press;
		int          fails_before;
		model_joy = last_exp;
		fails_before = fail_count;
		for (int n = 0; n < RANDOM_EVENTS; n++) begin
			k = $urandom_range(15, 0);
			press = 1'($urandom_range(1, 0));
			if (EXT_MASK[k])
				i_dev.send_byte(SC_EXT, 1'b0);
			if (!press)
				i_dev.send_byte(SC_BRK, 1'b0);
			i_dev.send_byte(KEY_CODE[k], 1'b0);
			model_joy[k] = press;
			wait_lines_idle();
			if (timed_out)
				break;
		end
		test_count++;
		if (!timed_out) begin
			compare_value("joystick", 32'(joystick), 32'(model_joy));
			$display("test %0d random events: %s", test_count - 1,
				(fail_count == fails_before) ? "ok" : "mismatch");
		end
	endtask

	initial begin
		rst_n = 1'b0;
		timed_out = 1'b0;
		err_pulses = 0;
		fail_count = 0;
		check_count = 0;
		test_count = 0;
		void'($urandom(32'hc90d_6af4));
		build_table();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			if (timed_out)
				break;
			run_row(i);
		end
		if (!timed_out)
			run_random_events();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, fail_count);
		if (fail_count == 0 && !timed_out)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/ps2_kbd_pkg.sv
verilog/key_event_if.sv
verilog/ps2_frame_rx.sv
verilog/scancode_parser.sv
verilog/joystick_mapper.sv
verilog/ps2_joystick_top.sv
verification/ps2_device_model.sv
verification/tb_ps2_joystick.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PS/2 joystick testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	-f build.f --top-module tb_ps2_joystick \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0
